/* src.f */
+incdir+src
src/dl1_pkg.sv
src/dl1_way_array.sv
src/dl1_request_ctrl.sv
src/dl1_l2_issue.sv
src/dl1_cache.sv
test/tb_clock.sv
test/l2_model.sv
test/dl1_cache_tb.sv

/* src/dl1_cache.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dl1_settings.svh"

module dl1_cache (
   input  wire                     clk,
   input  wire                     rst_n,
   input  wire                     flush,
   input  wire dl1_pkg::cpu_req_s  cpu_req,
   output wire [31:0]              rdata,
   output wire                     ready,
   output dl1_pkg::l2_req_s        l2_req,
   input  wire dl1_pkg::line_t     l2_rdata,
   input  wire                     l2_rvalid,
   input  wire                     l2_stall
);

   import dl1_pkg::*;

   cpu_req_s                               cur_req;
   logic                                   rd_addr_imm;
   logic                                   read_miss;
   logic                                   write_go;
   logic                                   fill;
   logic                                   hit;
   line_t                                  hit_line;
   line_t                                  merged_line;
   logic [`DL1_TAG_BITS+`DL1_SET_BITS-1:0] l2_addr_now;

   dl1_request_ctrl u_ctrl (
      .clk         (clk),
      .rst_n       (rst_n),
      .cpu_req     (cpu_req),
      .hit         (hit),
      .l2_rvalid   (l2_rvalid),
      .l2_stall    (l2_stall),
      .l2_addr_now (l2_addr_now),
      .cur_req     (cur_req),
      .rd_addr_imm (rd_addr_imm),
      .read_miss   (read_miss),
      .write_go    (write_go),
      .ready       (ready),
      .fill        (fill)
   );

   // Stores rewrite the hit way with the merged line
   dl1_way_array u_ways (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush       (flush),
      .next_set    (cpu_req.addr.f.set),
      .rd_addr_imm (rd_addr_imm),
      .cur_addr    (cur_req.addr),
      .req_active  (cur_req.re || (|cur_req.we)),
      .fill        (fill),
      .fill_line   (l2_rdata),
      .store       (write_go),
      .store_line  (merged_line),
      .hit         (hit),
      .hit_line    (hit_line)
   );

   dl1_l2_issue u_issue (
      .clk         (clk),
      .rst_n       (rst_n),
      .cur_req     (cur_req),
      .hit_line    (hit_line),
      .read_miss   (read_miss),
      .write_go    (write_go),
      .l2_stall    (l2_stall),
      .merged_line (merged_line),
      .l2_req      (l2_req),
      .l2_addr_now (l2_addr_now)
   );

   // Word select from the line read out for the held request
   assign rdata = hit_line[cur_req.addr.f.offs * 32 +: 32];

endmodule

`default_nettype wire

/* src/dl1_l2_issue.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dl1_settings.svh"

module dl1_l2_issue (
   input  wire                                   clk,
   input  wire                                   rst_n,
   input  wire dl1_pkg::cpu_req_s                cur_req,
   input  wire dl1_pkg::line_t                   hit_line,
   input  wire                                   read_miss,
   input  wire                                   write_go,
   input  wire                                   l2_stall,
   output dl1_pkg::line_t                        merged_line,
   output dl1_pkg::l2_req_s                      l2_req,
   output logic [`DL1_TAG_BITS+`DL1_SET_BITS-1:0] l2_addr_now
);

   import dl1_pkg::*;

   logic [31:0]                            bit_mask;
   logic [`DL1_OFFS_BITS-1:0]              offs;
   logic [`DL1_TAG_BITS+`DL1_SET_BITS-1:0] line_addr;
   line_be_t                               wbe;
   l2_req_s                                nxt_req;
   // The register holds a read that was sent for the current miss
   logic                                   rd_out;
   logic                                   rd_suppress;

   assign offs      = cur_req.addr.f.offs;
   assign line_addr = cur_req.addr.raw[$bits(word_addr_u)-1:`DL1_OFFS_BITS];

   always_comb begin
      for (int b = 0; b < 4; b++) begin
         bit_mask[8*b +: 8] = {8{cur_req.we[b]}};
      end
   end

   // Clear the enabled bytes of the word, then drop the store data in
   assign merged_line = (hit_line & ~(line_t'(bit_mask) << (32 * offs)))
                      | (line_t'(cur_req.wdata & bit_mask) << (32 * offs));
   assign wbe         = line_be_t'(cur_req.we) << (4 * offs);

   assign l2_addr_now = l2_req.addr;
   assign rd_suppress = rd_out && (l2_req.addr == line_addr);

   always_comb begin
      nxt_req       = l2_req;
      nxt_req.valid = 1'b0;
      if (read_miss) begin
         nxt_req.valid  = !rd_suppress;
         nxt_req.opcode = `DL1_OPC_READ;
         nxt_req.addr   = line_addr;
      end else if (write_go) begin
         nxt_req.valid  = 1'b1;
         nxt_req.opcode = `DL1_OPC_WRITE;
         nxt_req.addr   = line_addr;
         nxt_req.wdata  = merged_line;
         nxt_req.wbe    = wbe;
      end
   end

   always_ff @(posedge clk) begin
      if (!l2_stall) begin
         l2_req <= nxt_req;
      end
      if (!rst_n) begin
         l2_req.valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n || !read_miss) begin
         rd_out <= 1'b0;
      end else if (!l2_stall && nxt_req.valid) begin
         rd_out <= 1'b1;
      end
   end

endmodule

`default_nettype wire

/* src/dl1_pkg.sv */
`default_nettype none

`include "dl1_settings.svh"

package dl1_pkg;

   // Field view of a word address, tag in the upper bits
   typedef struct packed {
      logic [`DL1_TAG_BITS-1:0]  tag;
      logic [`DL1_SET_BITS-1:0]  set;
      logic [`DL1_OFFS_BITS-1:0] offs;
   } word_addr_fields_s;

   // Raw view gives the line address as its upper 27 bits
   typedef union packed {
      logic [`DL1_TAG_BITS+`DL1_SET_BITS+`DL1_OFFS_BITS-1:0] raw;
      word_addr_fields_s                                     f;
   } word_addr_u;

   typedef logic [`DL1_LINE_BITS-1:0]  line_t;
   typedef logic [`DL1_LINE_BYTES-1:0] line_be_t;

   // One CPU access; active when re is set or any byte enable is set
   typedef struct packed {
      word_addr_u  addr;
      logic        re;
      logic [3:0]  we;
      logic [31:0] wdata;
   } cpu_req_s;

   // Outgoing level-two request
   typedef struct packed {
      logic                                   valid;
      logic [2:0]                             opcode;
      logic [`DL1_TAG_BITS+`DL1_SET_BITS-1:0] addr;
      line_t                                  wdata;
      line_be_t                               wbe;
   } l2_req_s;

endpackage

`default_nettype wire

/* src/dl1_request_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dl1_settings.svh"

module dl1_request_ctrl (
   input  wire                                     clk,
   input  wire                                     rst_n,
   input  wire dl1_pkg::cpu_req_s                  cpu_req,
   input  wire                                     hit,
   input  wire                                     l2_rvalid,
   input  wire                                     l2_stall,
   input  wire [`DL1_TAG_BITS+`DL1_SET_BITS-1:0]   l2_addr_now,
   output dl1_pkg::cpu_req_s                       cur_req,
   output logic                                    rd_addr_imm,
   output logic                                    read_miss,
   output logic                                    write_go,
   output logic                                    ready,
   output logic                                    fill
);

   import dl1_pkg::*;

   // Held request, split into control and payload
   logic                                   req_re;
   logic [3:0]                             req_we;
   word_addr_u                             req_addr;
   logic [31:0]                            req_wdata;

   logic                                   req_active;
   logic                                   write_rem;
   logic                                   store_pend;
   logic [`DL1_TAG_BITS+`DL1_SET_BITS-1:0] line_addr;

   always_comb begin
      cur_req.addr  = req_addr;
      cur_req.re    = req_re;
      cur_req.we    = req_we;
      cur_req.wdata = req_wdata;
   end

   assign req_active = req_re || (|req_we);
   assign line_addr  = req_addr.raw[$bits(word_addr_u)-1:`DL1_OFFS_BITS];

   // A store still owes its write-through once the line is present
   assign store_pend = write_rem && (|req_we);

   // Any miss, read or write, first brings the line in
   assign read_miss = req_active && !hit;

   // Fill data counts only for the line we are waiting on
   assign fill = read_miss && l2_rvalid && !l2_stall && (l2_addr_now == line_addr);

   assign write_go = !read_miss && store_pend && !l2_stall;

   // Done once the line is present and nothing is left to write
   assign ready       = !read_miss && !store_pend;
   assign rd_addr_imm = ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         req_re    <= 1'b0;
         req_we    <= '0;
         write_rem <= 1'b0;
      end else if (ready) begin
         req_re    <= cpu_req.re;
         req_we    <= cpu_req.we;
         write_rem <= 1'b1;
      end else if (write_go) begin
         write_rem <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ready) begin
         req_addr  <= cpu_req.addr;
         req_wdata <= cpu_req.wdata;
      end
   end

endmodule

`default_nettype wire

/* src/dl1_settings.svh */
`ifndef DL1_SETTINGS_SVH
`define DL1_SETTINGS_SVH

// Cache geometry
`define DL1_WAYS 2
`define DL1_SETS 16
`define DL1_SET_BITS 4

// Word within a line
`define DL1_OFFS_BITS 3

// Line size, same as the level-two line
`define DL1_LINE_BYTES 32
`define DL1_LINE_BITS 256

// 30-bit word address minus set and offset
`define DL1_TAG_BITS 23

// Level-two opcodes
`define DL1_OPC_READ 3'b001
`define DL1_OPC_WRITE 3'b010

`endif

/* src/dl1_way_array.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dl1_settings.svh"

module dl1_way_array (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire                      flush,
   input  wire [`DL1_SET_BITS-1:0]  next_set,
   input  wire                      rd_addr_imm,
   input  wire dl1_pkg::word_addr_u cur_addr,
   input  wire                      req_active,
   input  wire                      fill,
   input  wire dl1_pkg::line_t      fill_line,
   input  wire                      store,
   input  wire dl1_pkg::line_t      store_line,
   output logic                     hit,
   output dl1_pkg::line_t           hit_line
);

   import dl1_pkg::*;

   logic [`DL1_TAG_BITS-1:0] tag_mem [`DL1_WAYS][`DL1_SETS];
   line_t                    data_mem [`DL1_WAYS][`DL1_SETS];
   logic [`DL1_SETS-1:0]     valid [`DL1_WAYS];
   // Per set, the way to replace on the next fill
   logic [`DL1_SETS-1:0]     evict;

   logic [`DL1_TAG_BITS-1:0] q_tag [`DL1_WAYS];
   line_t                    q_data [`DL1_WAYS];
   logic [`DL1_WAYS-1:0]     q_valid;
   logic [`DL1_WAYS-1:0]     hit_way;
   logic                     hit_idx;
   logic [`DL1_SET_BITS-1:0] cur_set;
   logic [`DL1_SET_BITS-1:0] rd_set;
   logic [`DL1_WAYS-1:0]     way_we;
   line_t                    wr_line;

   assign cur_set = cur_addr.f.set;
   // Look ahead to the incoming request while the controller accepts one
   assign rd_set = rd_addr_imm ? next_set : cur_set;

   always_comb begin
      for (int w = 0; w < `DL1_WAYS; w++) begin
         hit_way[w] = q_valid[w] && (q_tag[w] == cur_addr.f.tag);
      end
   end

   // With two ways the hitting way is simply whether way 1 hit
   assign hit_idx  = hit_way[1];
   assign hit      = |hit_way;
   assign hit_line = q_data[hit_idx];

   always_comb begin
      way_we  = '0;
      wr_line = store_line;
      if (fill) begin
         way_we[evict[cur_set]] = 1'b1;
         wr_line                = fill_line;
      end else if (store) begin
         way_we[hit_idx] = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      for (int w = 0; w < `DL1_WAYS; w++) begin
         if (way_we[w]) begin
            tag_mem[w][cur_set]  <= cur_addr.f.tag;
            data_mem[w][cur_set] <= wr_line;
         end
         q_tag[w]  <= tag_mem[w][rd_set];
         q_data[w] <= data_mem[w][rd_set];
      end
   end

   // Valid is sampled with the tag so a fresh fill shows up together with its data
   always_ff @(posedge clk) begin
      if (!rst_n || flush) begin
         evict   <= '0;
         q_valid <= '0;
         for (int w = 0; w < `DL1_WAYS; w++) begin
            valid[w] <= '0;
         end
      end else begin
         for (int w = 0; w < `DL1_WAYS; w++) begin
            q_valid[w] <= valid[w][rd_set];
         end
         if (fill) begin
            valid[evict[cur_set]][cur_set] <= 1'b1;
         end
         // Point replacement at the way that did not hit
         if (req_active && hit) begin
            evict[cur_set] <= ~hit_idx;
         end
      end
   end

endmodule

`default_nettype wire

/* test/dl1_cache_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module dl1_cache_tb;

   import dl1_pkg::*;

   localparam int          n_ops     = 40 + 32 + 12 + 3 + 40;
   localparam int          cycle_cap = n_ops * 64;
   localparam logic [19:0] tag_hi    = 20'h2b5c1;

   wire         clk;
   wire         rst_n;
   logic        flush;
   cpu_req_s    cpu_req;
   logic [31:0] rdata;
   logic        ready;
   l2_req_s     l2_req;
   line_t       l2_rdata;
   logic        l2_rvalid;
   logic        l2_stall;
   logic [7:0]  stall_pct;

   // Shadow memory indexed by {tag[2:0], set, offs}
   logic [31:0]   shadow [1024];
   logic [1023:0] shadow_set = '0;
   logic [22:0]   ref_tag [2][16];
   logic          ref_valid [2][16];
   logic          ref_evict [16];

   logic [31:0] seed    = 32'd3873;
   int          err_cnt = 0;
   int          op_cnt  = 0;
   int          cycles  = 0;

   // Result expected at the next ready cycle
   logic        chk_armed = 1'b0;
   logic        chk_read;
   logic [31:0] chk_exp;
   string       chk_name;

   tb_clock clk_gen (.clk(clk), .rst_n(rst_n));

   l2_model l2 (
      .clk       (clk),
      .rst_n     (rst_n),
      .l2_req    (l2_req),
      .stall_pct (stall_pct),
      .l2_rdata  (l2_rdata),
      .l2_rvalid (l2_rvalid),
      .l2_stall  (l2_stall)
   );

   dl1_cache dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .cpu_req   (cpu_req),
      .rdata     (rdata),
      .ready     (ready),
      .l2_req    (l2_req),
      .l2_rdata  (l2_rdata),
      .l2_rvalid (l2_rvalid),
      .l2_stall  (l2_stall)
   );

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic int rand_below(input int n);
      seed = lcg_next(seed);
      return int'(seed[30:16]) % n;
   endfunction

   function automatic logic [31:0] pattern_word(input logic [29:0] a);
      return ({a, 2'b00} * 32'h9e3779b1) ^ 32'h5bd1e995;
   endfunction

   function automatic word_addr_u make_addr(input int t, input int set, input int offs);
      word_addr_u a;
      a.f.tag  = {tag_hi, 3'(t)};
      a.f.set  = 4'(set);
      a.f.offs = 3'(offs);
      return a;
   endfunction

   function automatic logic [31:0] expected_word(input word_addr_u a);
      return shadow_set[a.raw[9:0]] ? shadow[a.raw[9:0]] : pattern_word(a.raw);
   endfunction

   task automatic store_shadow(input word_addr_u a, input logic [3:0] we,
                               input logic [31:0] wdata);
      logic [31:0] w;
      w = expected_word(a);
      for (int b = 0; b < 4; b++) begin
         if (we[b]) w[8*b +: 8] = wdata[8*b +: 8];
      end
      shadow[a.raw[9:0]]     = w;
      shadow_set[a.raw[9:0]] = 1'b1;
   endtask

   // Hits a valid matching way or else fills the evict way
   // The way just used is never the next to evict
   function automatic logic predict_miss(input word_addr_u a);
      logic miss;
      logic way;
      miss = 1'b1;
      way  = ref_evict[a.f.set];
      for (int w = 0; w < 2; w++) begin
         if (ref_valid[w][a.f.set] && ref_tag[w][a.f.set] == a.f.tag) begin
            miss = 1'b0;
            way  = (w == 1);
         end
      end
      ref_tag[way][a.f.set]   = a.f.tag;
      ref_valid[way][a.f.set] = 1'b1;
      ref_evict[a.f.set]      = ~way;
      return miss;
   endfunction

   task automatic clear_ref_state();
      for (int s = 0; s < 16; s++) begin
         ref_valid[0][s] = 1'b0;
         ref_valid[1][s] = 1'b0;
         ref_evict[s]    = 1'b0;
      end
   endtask

   task automatic report_mismatch(input string name, input string what,
                                  input logic [255:0] exp, input logic [255:0] act);
      $display("ERROR %s %s: expected %0h, actual %0h", name, what, exp, act);
      err_cnt++;
   endtask

   task automatic run_op(input string name, input logic re, input logic [3:0] we,
                         input word_addr_u a, input logic [31:0] wdata);
      logic        miss;
      int          rd0;
      int          wr0;
      int          waited;
      int          pos;
      l2_req_s     wr;
      line_be_t    exp_wbe;
      logic [26:0] line_addr;
      miss      = predict_miss(a);
      line_addr = a.raw[29:3];
      rd0       = l2.rd_cnt;
      wr0       = l2.wr_cnt;
      cpu_req.addr  = a;
      cpu_req.re    = re;
      cpu_req.we    = we;
      cpu_req.wdata = wdata;
      @(negedge clk);
      cpu_req.re = 1'b0;
      cpu_req.we = 4'h0;
      chk_name   = name;
      chk_read   = re;
      chk_exp    = expected_word(a);
      chk_armed  = 1'b1;
      if (we != 4'h0) store_shadow(a, we, wdata);
      op_cnt++;
      waited = 0;
      while (!ready) begin
         @(negedge clk);
         waited++;
      end
      // The model logs a write at the same falling edge, so look one edge later
      @(posedge clk);
      if (l2.rd_cnt - rd0 != (miss ? 1 : 0)) begin
         report_mismatch(name, "L2 reads", miss ? 1 : 0, l2.rd_cnt - rd0);
      end
      if (miss && l2.last_rd_addr !== line_addr) begin
         report_mismatch(name, "L2 read addr", line_addr, l2.last_rd_addr);
      end
      if (!miss && we == 4'h0 && waited != 0) begin
         report_mismatch(name, "hit wait cycles", 0, waited);
      end
      if (we != 4'h0) begin
         wr = l2.last_wr;
         // Four byte enables per word, placed at the word's slot in the line
         exp_wbe = '0;
         for (int b = 0; b < 4; b++) begin
            exp_wbe[4 * a.f.offs + b] = we[b];
         end
         if (l2.wr_cnt - wr0 != 1) begin
            report_mismatch(name, "L2 writes", 1, l2.wr_cnt - wr0);
         end else begin
            if (wr.addr !== line_addr) report_mismatch(name, "L2 write addr", line_addr, wr.addr);
            if (wr.wbe !== exp_wbe) begin
               report_mismatch(name, "L2 wbe", exp_wbe, wr.wbe);
            end
            for (int b = 0; b < 4; b++) begin
               pos = 32 * a.f.offs + 8 * b;
               if (we[b] && wr.wdata[pos +: 8] !== wdata[8*b +: 8]) begin
                  report_mismatch(name, "L2 write byte", wdata[8*b +: 8], wr.wdata[pos +: 8]);
               end
            end
         end
      end
      @(negedge clk);
   endtask

   task automatic flush_cache();
      flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      clear_ref_state();
   endtask

   task automatic print_test_result(input string name, input int ops, input int e0);
      $display("%s: %0d ops, %0d errors", name, ops, err_cnt - e0);
   endtask

   task automatic random_reads();
      int e0;
      e0 = err_cnt;
      for (int i = 0; i < 40; i++) begin
         run_op("reads", 1'b1, 4'h0, make_addr(rand_below(4), rand_below(4), rand_below(8)), 0);
      end
      print_test_result("reads", 40, e0);
   endtask

   task automatic store_then_read();
      int          e0;
      word_addr_u  a;
      logic [3:0]  we;
      e0 = err_cnt;
      for (int i = 0; i < 16; i++) begin
         a    = make_addr(rand_below(4), rand_below(4), rand_below(8));
         we   = 4'(rand_below(15) + 1);
         seed = lcg_next(seed);
         run_op("store_merge", 1'b0, we, a, seed);
         run_op("store_merge", 1'b1, 4'h0, a, 0);
      end
      print_test_result("store_merge", 32, e0);
   endtask

   // Three tags fighting over the two ways of set 9
   task automatic three_tag_eviction();
      int e0;
      int seq [12];
      e0  = err_cnt;
      seq = '{0, 1, 0, 2, 1, 0, 2, 2, 0, 1, 1, 2};
      for (int i = 0; i < 12; i++) begin
         run_op("evict", 1'b1, 4'h0, make_addr(seq[i] + 5, 9, i % 8), 0);
      end
      print_test_result("evict", 12, e0);
   endtask

   task automatic read_after_flush();
      int e0;
      e0 = err_cnt;
      run_op("flush", 1'b1, 4'h0, make_addr(3, 2, 5), 0);
      run_op("flush", 1'b1, 4'h0, make_addr(3, 2, 5), 0);
      flush_cache();
      run_op("flush", 1'b1, 4'h0, make_addr(3, 2, 5), 0);
      print_test_result("flush", 3, e0);
   endtask

   task automatic stalled_traffic();
      int e0;
      e0 = err_cnt;
      stall_pct <= 8'd75;
      for (int i = 0; i < 40; i++) begin
         seed = lcg_next(seed);
         if (rand_below(3) == 0) begin
            run_op("heavy_stall", 1'b0, 4'(rand_below(15) + 1),
                   make_addr(rand_below(6), rand_below(4), rand_below(8)), seed);
         end else begin
            run_op("heavy_stall", 1'b1, 4'h0,
                   make_addr(rand_below(6), rand_below(4), rand_below(8)), 0);
         end
      end
      stall_pct <= 8'd20;
      print_test_result("heavy_stall", 40, e0);
   endtask

   // Read data is compared at the rising edge that ends the request
   always @(posedge clk) begin
      if (chk_armed && ready) begin
         if (chk_read && rdata !== chk_exp) begin
            report_mismatch(chk_name, "rdata", chk_exp, rdata);
         end
         chk_armed = 1'b0;
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_cap) begin
         $display("Run stopped after %0d cycles, the cache stopped completing requests", cycles);
         $display("Test failed");
         $finish;
      end
   end

   initial begin
      flush     = 1'b0;
      cpu_req   = '0;
      stall_pct = 8'd20;
      clear_ref_state();
      @(posedge rst_n);
      random_reads();
      store_then_read();
      three_tag_eviction();
      read_after_flush();
      stalled_traffic();
      $display("total: %0d ops, %0d errors", op_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* test/l2_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "dl1_settings.svh"

module l2_model (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire dl1_pkg::l2_req_s  l2_req,
   input  wire [7:0]              stall_pct,
   output dl1_pkg::line_t         l2_rdata,
   output logic                   l2_rvalid,
   output logic                   l2_stall
);

   import dl1_pkg::*;

   // 128 lines, each filled from the address pattern on first touch
   line_t        mem [128];
   logic [127:0] touched = '0;
   logic [31:0]  seed = 32'd3873;
   logic         rd_busy = 1'b0;
   logic [26:0]  rd_addr;
   int           rd_wait;

   // Log of accepted requests
   int           rd_cnt = 0;
   int           wr_cnt = 0;
   logic [26:0]  last_rd_addr;
   l2_req_s      last_wr;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   function automatic logic [31:0] pattern_word(input logic [29:0] a);
      return ({a, 2'b00} * 32'h9e3779b1) ^ 32'h5bd1e995;
   endfunction

   task automatic touch_line(input logic [26:0] a);
      if (!touched[a[6:0]]) begin
         for (int k = 0; k < 8; k++) begin
            mem[a[6:0]][32*k +: 32] = pattern_word({a, 3'(k)});
         end
         touched[a[6:0]] = 1'b1;
      end
   endtask

   initial begin
      l2_rvalid = 1'b0;
      l2_stall  = 1'b0;
      l2_rdata  = '0;
   end

   // Stall here still holds the value the cache saw at the last rising edge
   always @(negedge clk) begin
      if (rst_n) begin
         if (l2_rvalid && !l2_stall) begin
            l2_rvalid = 1'b0;
            rd_busy   = 1'b0;
         end
         if (!l2_stall && l2_req.valid) begin
            touch_line(l2_req.addr);
            if (l2_req.opcode == `DL1_OPC_READ) begin
               rd_cnt++;
               last_rd_addr = l2_req.addr;
               rd_addr      = l2_req.addr;
               rd_busy      = 1'b1;
               seed         = lcg_next(seed);
               rd_wait      = int'(seed[18:16]);
            end else if (l2_req.opcode == `DL1_OPC_WRITE) begin
               wr_cnt++;
               last_wr = l2_req;
               for (int b = 0; b < 32; b++) begin
                  if (l2_req.wbe[b]) begin
                     mem[l2_req.addr[6:0]][8*b +: 8] = l2_req.wdata[8*b +: 8];
                  end
               end
            end
         end
         if (rd_busy && !l2_rvalid) begin
            if (rd_wait == 0) begin
               l2_rdata  = mem[rd_addr[6:0]];
               l2_rvalid = 1'b1;
            end else begin
               rd_wait--;
            end
         end
         seed     = lcg_next(seed);
         l2_stall = (int'(seed[23:16]) % 100) < int'(stall_pct);
      end
   end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
   parameter real half_period  = 2.0,
   parameter int  reset_cycles = 5
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(half_period) clk = ~clk;
   end

   // Release on a falling edge, like every other input
   initial begin
      rst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

`default_nettype wire
